// ==== Makefile ====
# Verilator build and run of the execute stage testbench

TOP := exu_tb
LOG := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		-f exu.f --top-module $(TOP) -Mdir obj_dir -o $(TOP)
	./obj_dir/$(TOP) | tee $(LOG)
	@if grep -qx "TESTBENCH PASSED" $(LOG); then \
		echo "result: pass"; \
	else \
		echo "result: fail"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir $(LOG)

// ==== exu.f ====
+incdir+verilog
verilog/exu_pkg.sv
verilog/exu_alu.sv
verilog/exu_csu.sv
verilog/exu_retire.sv
verilog/exu_top.sv
sim/exu_tb.sv

// ==== sim/exu_tb.sv ====
// directed testbench for exu_top acting as issuer and writeback; fixed seed, 64-bit data assumed
`default_nettype none

`include "exu_defs.svh"

module exu_tb
  import exu_pkg::*;
;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int QD         = `EXU_QUEUE_DEPTH;
  localparam int OUT        = `EXU_OUT_CREDITS;
  localparam int STREAM_LEN = 200;
  localparam int TOTAL_OPS  = 66 + 20 + 12 + 3 + QD + OUT + STREAM_LEN;
  localparam int CYCLE_LIMIT = 4 * TOTAL_OPS + 200;

  logic        clk = 1'b0;
  logic        rst;
  logic        issue_valid;
  exu_issue_t  issue_pkt;
  logic        issue_credit;
  logic        result_valid;
  exu_result_t result;
  logic        result_credit = 1'b0;

  exu_result_t exp_q [$];
  logic        tag_seen [256];
  logic [7:0]  next_tag = '0;
  int          issue_credits = QD;
  int          credits_back = 0;
  int          outstanding = 0;
  int          delivered = 0;
  int          errors = 0;
  int          cycles = 0;
  // 0 withheld, 1 every cycle, 2 random
  int          credit_mode = 1;

  always #5 clk = ~clk;

  exu_top dut0 (
    .i_clk           (clk),
    .i_rst           (rst),
    .i_issue_valid   (issue_valid),
    .i_issue         (issue_pkt),
    .o_issue_credit  (issue_credit),
    .o_result_valid  (result_valid),
    .o_result        (result),
    .i_result_credit (result_credit)
  );

  function automatic logic [63:0] full_op(input exu_alu_op_e op, input logic [63:0] a,
                                          input logic [63:0] b);
    case (op)
      ALU_ADD:  return a + b;
      ALU_SUB:  return a - b;
      ALU_SLL:  return a << b[5:0];
      ALU_SLT:  return {63'd0, $signed(a) < $signed(b)};
      ALU_SLTU: return {63'd0, a < b};
      ALU_XOR:  return a ^ b;
      ALU_SRL:  return a >> b[5:0];
      ALU_SRA:  return $signed(a) >>> b[5:0];
      ALU_OR:   return a | b;
      ALU_AND:  return a & b;
      ALU_LUI:  return b;
      default:  return '0;
    endcase
  endfunction

  // rv64 word forms work on 32 bits, then sign extend
  function automatic logic [63:0] word_op(input exu_alu_op_e op, input logic [31:0] a,
                                          input logic [31:0] b);
    logic [31:0] r;
    case (op)
      ALU_ADD: r = a + b;
      ALU_SUB: r = a - b;
      ALU_SLL: r = a << b[4:0];
      ALU_SRL: r = a >> b[4:0];
      ALU_SRA: r = $signed(a) >>> b[4:0];
      default: r = '0;
    endcase
    return {{32{r[31]}}, r};
  endfunction

  function automatic exu_result_t expected_result(input exu_issue_t p);
    exu_result_t r;
    logic [63:0] a;
    logic [63:0] b;
    logic [63:0] src;
    r         = '0;
    r.tag     = p.tag;
    r.ebreak  = p.ebreak;
    r.invalid = p.invalid;
    if (p.unit == UNIT_ALU) begin
      a = p.src1_pc ? p.pc : p.rs1;
      case (p.src2_sel)
        SRC2_RS2: b = p.rs2;
        SRC2_IMM: b = p.imm;
        default:  b = 64'd4;
      endcase
      r.rd_value = p.word ? word_op(p.op.alu, a[31:0], b[31:0]) : full_op(p.op.alu, a, b);
    end else if (p.unit == UNIT_CSR) begin
      src = p.op.csr.use_imm ? {59'd0, p.imm[4:0]} : p.rs1;
      r.rd_value = p.csr_rdata;
      case (p.op.csr.kind)
        CSR_RW: r.csr_wdata = src;
        CSR_RS: r.csr_wdata = p.csr_rdata | src;
        default: r.csr_wdata = p.csr_rdata & ~src;
      endcase
      // set and clear with a zero source leave the csr alone
      r.csr_we = (p.op.csr.kind == CSR_RW) || (src != '0);
    end
    return r;
  endfunction

  function automatic exu_issue_t random_packet(input exu_unit_e unit);
    exu_issue_t p;
    p           = '0;
    p.rs1       = {$urandom, $urandom};
    p.rs2       = {$urandom, $urandom};
    p.imm       = {$urandom, $urandom};
    p.pc        = {$urandom, $urandom};
    p.csr_rdata = {$urandom, $urandom};
    p.unit      = unit;
    p.tag       = next_tag;
    next_tag    = next_tag + 8'd1;
    if (unit == UNIT_ALU) begin
      p.op.alu   = exu_alu_op_e'(5'($urandom % 11));
      p.src1_pc  = 1'($urandom);
      p.src2_sel = exu_src2_e'(2'($urandom % 3));
      p.word = 1'($urandom) && (p.op.alu inside {ALU_ADD, ALU_SUB, ALU_SLL, ALU_SRL, ALU_SRA});
    end else if (unit == UNIT_CSR) begin
      p.op.csr.kind    = exu_csr_kind_e'(2'($urandom % 3));
      p.op.csr.use_imm = 1'($urandom);
    end else begin
      p.ebreak = 1'($urandom);
    end
    return p;
  endfunction

  task automatic drive(input exu_issue_t p);
    issue_pkt   = p;
    issue_valid = 1'b1;
    issue_credits--;
    exp_q.push_back(expected_result(p));
  endtask

  // called on a falling edge, returns on one
  task automatic send(input exu_issue_t p);
    while (issue_credits == 0) @(negedge clk);
    drive(p);
    @(negedge clk);
    issue_valid = 1'b0;
  endtask

  task automatic drain();
    while (exp_q.size() != 0 || outstanding != 0) @(negedge clk);
    repeat (2) @(negedge clk);
  endtask

  task automatic compare_value(input string name, input logic [63:0] got,
                               input logic [63:0] want);
    if (got !== want) begin
      $display("ERR %s got %h expected %h", name, got, want);
      errors++;
    end
  endtask

  task automatic alu_op_sweep();
    exu_issue_t p;
    for (int op = 0; op < 11; op++) begin
      for (int s1 = 0; s1 < 2; s1++) begin
        for (int s2 = 0; s2 < 3; s2++) begin
          p          = random_packet(UNIT_ALU);
          p.op.alu   = exu_alu_op_e'(5'(op));
          p.src1_pc  = 1'(s1);
          p.src2_sel = exu_src2_e'(2'(s2));
          p.word     = 1'b0;
          send(p);
        end
      end
    end
  endtask

  task automatic word_form_sweep();
    exu_issue_t  p;
    exu_alu_op_e ops [5] = '{ALU_ADD, ALU_SUB, ALU_SLL, ALU_SRL, ALU_SRA};
    for (int i = 0; i < 5; i++) begin
      for (int j = 0; j < 4; j++) begin
        p          = random_packet(UNIT_ALU);
        p.op.alu   = ops[i];
        p.word     = 1'b1;
        p.src1_pc  = 1'b0;
        p.src2_sel = (j < 2) ? SRC2_RS2 : SRC2_IMM;
        // negative low word on odd passes
        p.rs1[31]  = 1'(j);
        send(p);
      end
    end
  endtask

  task automatic csr_op_sweep();
    exu_issue_t p;
    for (int k = 0; k < 3; k++) begin
      for (int u = 0; u < 2; u++) begin
        for (int z = 0; z < 2; z++) begin
          p                = random_packet(UNIT_CSR);
          p.op.csr.kind    = exu_csr_kind_e'(2'(k));
          p.op.csr.use_imm = 1'(u);
          if (z == 1) begin
            p.rs1      = '0;
            p.imm[4:0] = '0;
          end
          send(p);
        end
      end
    end
  endtask

  task automatic status_retire();
    exu_issue_t p;
    p = random_packet(UNIT_SYS);
    p.ebreak = 1'b1;
    send(p);
    p = random_packet(UNIT_SYS);
    p.ebreak  = 1'b0;
    p.invalid = 1'b1;
    send(p);
    p = random_packet(UNIT_SYS);
    p.ebreak = 1'b0;
    send(p);
  endtask

  task automatic back_pressure_hold();
    exu_issue_t p;
    int sent;
    int got0;
    int back0;
    drain();
    credit_mode = 0;
    sent  = 0;
    got0  = delivered;
    back0 = credits_back;
    // issue whenever a credit is held, for long enough to stall
    for (int i = 0; i < 40; i++) begin
      if (issue_credits > 0) begin
        p       = random_packet(UNIT_ALU);
        p.op.alu = ALU_ADD;
        drive(p);
        sent++;
      end else begin
        issue_valid = 1'b0;
      end
      @(negedge clk);
    end
    issue_valid = 1'b0;
    if (delivered - got0 != OUT) begin
      $display("with credits held %0d results left, expected %0d", delivered - got0, OUT);
      errors++;
    end
    if (sent != QD + OUT) begin
      $display("issuer sent %0d packets under back-pressure, expected %0d", sent, QD + OUT);
      errors++;
    end
    if (credits_back - back0 != delivered - got0) begin
      $display("issue credits returned do not match results delivered under back-pressure");
      errors++;
    end
    credit_mode = 1;
    drain();
    if (delivered - got0 != sent || credits_back - back0 != sent) begin
      $display("after release %0d results and %0d issue credits came back for %0d issues",
               delivered - got0, credits_back - back0, sent);
      errors++;
    end
  endtask

  task automatic mixed_stream();
    exu_issue_t p;
    drain();
    tag_seen    = '{default: 1'b0};
    next_tag    = '0;
    credit_mode = 2;
    for (int i = 0; i < STREAM_LEN; i++) begin
      p = random_packet(exu_unit_e'(2'($urandom % 3)));
      p.invalid = ($urandom % 8) == 0;
      send(p);
      if ($urandom % 4 == 0) @(negedge clk);
    end
    credit_mode = 1;
    drain();
    for (int t = 0; t < STREAM_LEN; t++) begin
      if (!tag_seen[t]) begin
        $display("stream tag %h never retired", t);
        errors++;
      end
    end
  endtask

  // writeback side returns credits for results it has taken
  always @(negedge clk) begin
    result_credit = 1'b0;
    if (outstanding > 0) begin
      if (credit_mode == 1) begin
        result_credit = 1'b1;
      end else if (credit_mode == 2) begin
        result_credit = ($urandom % 2) == 0;
      end
    end
    if (result_credit) begin
      outstanding--;
    end
  end

  always @(posedge clk) begin : check_proc
    exu_result_t want;
    cycles++;
    if (cycles >= CYCLE_LIMIT) begin
      $display("timeout, run stopped after %0d cycles with %0d results pending",
               cycles, exp_q.size());
      $display("TESTBENCH FAILED");
      $finish;
    end else if (!rst) begin
      if (issue_credit) begin
        issue_credits++;
        credits_back++;
      end
      if (result_valid) begin
        if (outstanding >= OUT) begin
          $display("result sent while no downstream credit was held");
          errors++;
        end
        outstanding++;
        delivered++;
        if (exp_q.size() == 0) begin
          $display("result with tag %h arrived when none was expected", result.tag);
          errors++;
        end else begin
          want = exp_q.pop_front();
          compare_value("o_result.tag", 64'(result.tag), 64'(want.tag));
          compare_value("o_result.rd_value", result.rd_value, want.rd_value);
          compare_value("o_result.csr_wdata", result.csr_wdata, want.csr_wdata);
          compare_value("o_result.csr_we", 64'(result.csr_we), 64'(want.csr_we));
          compare_value("o_result.ebreak", 64'(result.ebreak), 64'(want.ebreak));
          compare_value("o_result.invalid", 64'(result.invalid), 64'(want.invalid));
          if (tag_seen[result.tag]) begin
            $display("tag %h retired twice", result.tag);
            errors++;
          end
          tag_seen[result.tag] = 1'b1;
        end
      end
    end
  end

  initial begin
    void'($urandom(69));
    rst         = 1'b1;
    issue_valid = 1'b0;
    issue_pkt   = '0;
    tag_seen    = '{default: 1'b0};
    repeat (4) @(negedge clk);
    rst = 1'b0;
    alu_op_sweep();
    word_form_sweep();
    csr_op_sweep();
    status_retire();
    back_pressure_hold();
    mixed_stream();
    drain();
    if (issue_credits != QD) begin
      $display("issuer ends with %0d credits instead of %0d", issue_credits, QD);
      errors++;
    end
    $display("run complete, %0d results checked, %0d errors", delivered, errors);
    if (errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== verilog/exu_alu.sv ====
// combinational integer alu; no mul/div, word forms cut operands to 32 bits, xlen >= 64 assumed
`default_nettype none

`include "exu_defs.svh"

module exu_alu
  import exu_pkg::*;
(
  input  exu_issue_t           i_issue,
  output logic [`EXU_XLEN-1:0] o_value
);

  logic [`EXU_XLEN-1:0] src_a_full;
  logic [`EXU_XLEN-1:0] src_b_full;
  logic [`EXU_XLEN-1:0] src_a;
  logic [`EXU_XLEN-1:0] src_b;
  logic [5:0]           shamt;
  logic [31:0]          sra_word;
  logic [`EXU_XLEN-1:0] raw;

  assign src_a_full = i_issue.src1_pc ? i_issue.pc : i_issue.rs1;

  always_comb begin
    case (i_issue.src2_sel)
      SRC2_RS2:  src_b_full = i_issue.rs2;
      SRC2_IMM:  src_b_full = i_issue.imm;
      SRC2_FOUR: src_b_full = `EXU_XLEN'(4);
      default:   src_b_full = '0;
    endcase
  end

  // word cut, zero extended like the full-width path expects
  assign src_a = i_issue.word ? {{(`EXU_XLEN-32){1'b0}}, src_a_full[31:0]} : src_a_full;
  assign src_b = i_issue.word ? {{(`EXU_XLEN-32){1'b0}}, src_b_full[31:0]} : src_b_full;

  // word shifts only take five bits of amount
  assign shamt = i_issue.word ? {1'b0, src_b[4:0]} : src_b[5:0];

  // sraw gets its sign from bit 31, not from the zero-extended top
  assign sra_word = $signed(src_a[31:0]) >>> shamt[4:0];

  always_comb begin
    case (i_issue.op.alu)
      ALU_ADD:  raw = src_a + src_b;
      ALU_SUB:  raw = src_a - src_b;
      ALU_SLL:  raw = src_a << shamt;
      ALU_SLT:  raw = {{(`EXU_XLEN-1){1'b0}}, $signed(src_a) < $signed(src_b)};
      ALU_SLTU: raw = {{(`EXU_XLEN-1){1'b0}}, src_a < src_b};
      ALU_XOR:  raw = src_a ^ src_b;
      ALU_SRL:  raw = src_a >> shamt;
      ALU_SRA: begin
        if (i_issue.word) begin
          raw = {{(`EXU_XLEN-32){1'b0}}, sra_word};
        end else begin
          raw = $signed(src_a) >>> shamt;
        end
      end
      ALU_OR:   raw = src_a | src_b;
      ALU_AND:  raw = src_a & src_b;
      ALU_LUI:  raw = src_b;
      default:  raw = '0;
    endcase
  end

  // word results sign extend from bit 31
  assign o_value = i_issue.word ? {{(`EXU_XLEN-32){raw[31]}}, raw[31:0]} : raw;

  // decoder must not hand an undefined op to the alu
  always_comb begin
    if (i_issue.unit == UNIT_ALU) begin
      a_alu_op_defined: assert final (i_issue.op.alu inside {[ALU_ADD:ALU_LUI]})
        else $error("exu_alu: undefined op %0h for alu unit", i_issue.op.alu);
    end
  end

endmodule

`default_nettype wire

// ==== verilog/exu_csu.sv ====
// csr unit for csrrw/csrrs/csrrc and their imm forms; the issuer supplies use_imm
`default_nettype none

`include "exu_defs.svh"

module exu_csu
  import exu_pkg::*;
(
  input  exu_issue_t             i_issue,
  output logic [`EXU_XLEN-1:0]   o_rd_value,
  output logic [`EXU_CSR_WD-1:0] o_csr_wdata,
  output logic                   o_csr_we
);

  exu_csr_view_t          view;
  logic [`EXU_CSR_WD-1:0] src;

  assign view = i_issue.op.csr;

  // uimm is the low five bits of imm, zero extended
  assign src = view.use_imm ? {{(`EXU_CSR_WD-5){1'b0}}, i_issue.imm[4:0]}
                            : `EXU_CSR_WD'(i_issue.rs1);

  // rd always gets the old csr value
  assign o_rd_value = `EXU_XLEN'(i_issue.csr_rdata);

  always_comb begin
    case (view.kind)
      CSR_RW: begin
        o_csr_wdata = src;
        o_csr_we    = 1'b1;
      end
      CSR_RS: begin
        o_csr_wdata = i_issue.csr_rdata | src;
        o_csr_we    = |src;
      end
      CSR_RC: begin
        o_csr_wdata = i_issue.csr_rdata & ~src;
        o_csr_we    = |src;
      end
      default: begin
        o_csr_wdata = i_issue.csr_rdata;
        o_csr_we    = 1'b0;
      end
    endcase
  end

  always_comb begin
    if (i_issue.unit == UNIT_CSR) begin
      a_csr_kind_defined: assert final (view.kind != 2'd3)
        else $error("exu_csu: reserved csr kind on csr unit");
    end
  end

endmodule

`default_nettype wire

// ==== verilog/exu_defs.svh ====
// widths and credit depths; both depths must be at least 1 and the widths at least 32

`ifndef EXU_DEFS_SVH
`define EXU_DEFS_SVH

// integer data word
`define EXU_XLEN 64

// csr value as read from and written back to the csr file
`define EXU_CSR_WD 64

// result queue entries, also the issuer's credit count after reset
`define EXU_QUEUE_DEPTH 4

// credits granted by writeback after reset
`define EXU_OUT_CREDITS 2

`endif

// ==== verilog/exu_pkg.sv ====
// issue and result types for the execute stage; op is read in two ways, see exu_op_u
`default_nettype none

package exu_pkg;

  `include "exu_defs.svh"

  typedef enum logic [1:0] {
    UNIT_ALU = 2'd0,
    UNIT_CSR = 2'd1,
    // ebreak and no-op
    UNIT_SYS = 2'd2
  } exu_unit_e;

  typedef enum logic [4:0] {
    ALU_ADD  = 5'd0,
    ALU_SUB  = 5'd1,
    ALU_SLL  = 5'd2,
    ALU_SLT  = 5'd3,
    ALU_SLTU = 5'd4,
    ALU_XOR  = 5'd5,
    ALU_SRL  = 5'd6,
    ALU_SRA  = 5'd7,
    ALU_OR   = 5'd8,
    ALU_AND  = 5'd9,
    // passes src_b through
    ALU_LUI  = 5'd10
  } exu_alu_op_e;

  typedef enum logic [1:0] {
    CSR_RW = 2'd0,
    CSR_RS = 2'd1,
    CSR_RC = 2'd2
  } exu_csr_kind_e;

  typedef struct packed {
    logic [1:0]    rsvd;
    logic          use_imm;
    exu_csr_kind_e kind;
  } exu_csr_view_t;

  // one decoded field, an alu op for the alu and a csr view for the csr unit
  typedef union packed {
    exu_alu_op_e   alu;
    exu_csr_view_t csr;
  } exu_op_u;

  typedef enum logic [1:0] {
    SRC2_RS2  = 2'd0,
    SRC2_IMM  = 2'd1,
    SRC2_FOUR = 2'd2
  } exu_src2_e;

  typedef struct packed {
    logic [`EXU_XLEN-1:0]   rs1;
    logic [`EXU_XLEN-1:0]   rs2;
    logic [`EXU_XLEN-1:0]   imm;
    logic [`EXU_XLEN-1:0]   pc;
    logic [`EXU_CSR_WD-1:0] csr_rdata;
    logic                   src1_pc;
    exu_src2_e              src2_sel;
    logic                   word;
    exu_unit_e              unit;
    exu_op_u                op;
    logic                   ebreak;
    logic                   invalid;
    logic [7:0]             tag;
  } exu_issue_t;

  typedef struct packed {
    logic [7:0]             tag;
    logic [`EXU_XLEN-1:0]   rd_value;
    logic [`EXU_CSR_WD-1:0] csr_wdata;
    logic                   csr_we;
    logic                   ebreak;
    logic                   invalid;
  } exu_result_t;

endpackage

`default_nettype wire

// ==== verilog/exu_retire.sv ====
// result queue with credit flow both ways; the issuer must hold a credit and results leave in order
`default_nettype none

`include "exu_defs.svh"

module exu_retire
  import exu_pkg::*;
(
  input  wire                    i_clk,
  input  wire                    i_rst,
  input  wire                    i_issue_valid,
  input  exu_issue_t             i_issue,
  input  wire [`EXU_XLEN-1:0]    i_alu_value,
  input  wire [`EXU_XLEN-1:0]    i_csr_rd_value,
  input  wire [`EXU_CSR_WD-1:0]  i_csr_wdata,
  input  wire                    i_csr_we,
  input  wire                    i_result_credit,
  output logic                   o_result_valid,
  output exu_result_t            o_result,
  output logic                   o_issue_credit
);

  localparam int QD = `EXU_QUEUE_DEPTH;
  localparam int PW = (QD > 1) ? $clog2(QD) : 1;
  localparam int CW = $clog2(`EXU_OUT_CREDITS + 1);

  exu_result_t   q_mem [QD];
  exu_result_t   push_data;
  logic [PW-1:0] wr_ptr;
  logic [PW-1:0] rd_ptr;
  logic [PW:0]   q_count;
  logic [CW-1:0] credits;
  logic          push;
  logic          pop;

  function automatic logic [PW-1:0] next_ptr(input logic [PW-1:0] ptr);
    next_ptr = (ptr == PW'(QD - 1)) ? '0 : ptr + 1'b1;
  endfunction

  always_comb begin
    push_data.tag     = i_issue.tag;
    push_data.ebreak  = i_issue.ebreak;
    push_data.invalid = i_issue.invalid;
    case (i_issue.unit)
      UNIT_ALU: begin
        push_data.rd_value  = i_alu_value;
        push_data.csr_wdata = '0;
        push_data.csr_we    = 1'b0;
      end
      UNIT_CSR: begin
        push_data.rd_value  = i_csr_rd_value;
        push_data.csr_wdata = i_csr_wdata;
        push_data.csr_we    = i_csr_we;
      end
      // sys covers ebreak and no-op
      default: begin
        push_data.rd_value  = '0;
        push_data.csr_wdata = '0;
        push_data.csr_we    = 1'b0;
      end
    endcase
  end

  assign push = i_issue_valid;
  assign pop  = (q_count != '0) && (credits != '0);

  assign o_result_valid = pop;
  assign o_result       = q_mem[rd_ptr];
  // entry freed this cycle goes straight back to the issuer
  assign o_issue_credit = pop;

  always_ff @(posedge i_clk) begin
    if (push) begin
      q_mem[wr_ptr] <= push_data;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      wr_ptr  <= '0;
      rd_ptr  <= '0;
      q_count <= '0;
      credits <= CW'(`EXU_OUT_CREDITS);
    end else begin
      if (push) begin
        wr_ptr <= next_ptr(wr_ptr);
      end
      if (pop) begin
        rd_ptr <= next_ptr(rd_ptr);
      end
      if (push && !pop) begin
        q_count <= q_count + 1'b1;
      end else if (pop && !push) begin
        q_count <= q_count - 1'b1;
      end
      // spend and return in one cycle cancel
      if (pop && !i_result_credit) begin
        credits <= credits - 1'b1;
      end else if (i_result_credit && !pop) begin
        credits <= credits + 1'b1;
      end
    end
  end

  // issuer overran its credits
  a_no_issue_when_full: assert property (@(posedge i_clk) disable iff (i_rst)
    i_issue_valid |-> q_count != (PW + 1)'(QD))
    else $error("exu_retire: issue while queue full");

  // writeback may not return more than it granted
  a_credit_bound: assert property (@(posedge i_clk) disable iff (i_rst)
    i_result_credit && !pop |-> credits < CW'(`EXU_OUT_CREDITS))
    else $error("exu_retire: downstream credit count above %0d", `EXU_OUT_CREDITS);

endmodule

`default_nettype wire

// ==== verilog/exu_top.sv ====
// execute stage top; issue and result sides are both credit based, see exu_retire
`default_nettype none

`include "exu_defs.svh"

module exu_top
  import exu_pkg::*;
(
  input  wire         i_clk,
  input  wire         i_rst,
  input  wire         i_issue_valid,
  input  exu_issue_t  i_issue,
  output logic        o_issue_credit,
  output logic        o_result_valid,
  output exu_result_t o_result,
  input  wire         i_result_credit
);

  logic [`EXU_XLEN-1:0]   alu_value;
  logic [`EXU_XLEN-1:0]   csr_rd_value;
  logic [`EXU_CSR_WD-1:0] csr_wdata;
  logic                   csr_we;

  exu_alu alu0 (
    .i_issue (i_issue),
    .o_value (alu_value)
  );

  exu_csu csu0 (
    .i_issue     (i_issue),
    .o_rd_value  (csr_rd_value),
    .o_csr_wdata (csr_wdata),
    .o_csr_we    (csr_we)
  );

  exu_retire retire0 (
    .i_clk           (i_clk),
    .i_rst           (i_rst),
    .i_issue_valid   (i_issue_valid),
    .i_issue         (i_issue),
    .i_alu_value     (alu_value),
    .i_csr_rd_value  (csr_rd_value),
    .i_csr_wdata     (csr_wdata),
    .i_csr_we        (csr_we),
    .i_result_credit (i_result_credit),
    .o_result_valid  (o_result_valid),
    .o_result        (o_result),
    .o_issue_credit  (o_issue_credit)
  );

endmodule

`default_nettype wire
